// File: flist.f
+incdir+src
+incdir+sim
src/rv_isa_pkg.sv
src/core_pkg.sv
src/insn_decode.sv
src/reg_file.sv
src/alu_execute.sv
src/pc_writeback.sv
src/rv_core.sv
sim/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Compile and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_rv_core -f flist.f -o tb_rv_core_sim

out=$(./obj_dir/tb_rv_core_sim)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi

// File: sim/tb_iss.svh
// ==============================
// Reference instruction-set model for the core testbench
// Include inside the testbench module; holds model state
// ==============================
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

logic [`XLEN-1:0] ref_pc;
logic [`XLEN-1:0] ref_regs [32];
logic [`XLEN-1:0] ref_imem [1024];
logic [`XLEN-1:0] ref_dmem [256];

function automatic logic [`XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// Runs one instruction on the model, returns what the core should show
function automatic void iss_step(output logic [31:0] pc_o, output logic [31:0] addr_o,
                                 output logic [31:0] wdata_o, output logic [3:0] be_o,
                                 output logic halt_o);
  rv_isa_pkg::insn_t in;
  logic [31:0] a, b, imm_i, imm_s, imm_b, imm_j, ea, res, nxt, word;
  logic [2:0] f3;
  logic [1:0] off;
  logic take, wr;
  in = ref_imem[ref_pc[11:2]];
  f3 = in.i_fmt.funct3;
  a = ref_regs[in.r_fmt.rs1];
  b = ref_regs[in.r_fmt.rs2];
  imm_i = {{20{in[31]}}, in[31:20]};
  imm_s = {{20{in[31]}}, in[31:25], in[11:7]};
  imm_b = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
  imm_j = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
  pc_o = ref_pc;
  addr_o = '0;
  wdata_o = '0;
  be_o = '0;
  halt_o = 1'b0;
  nxt = ref_pc + 32'd4;
  res = '0;
  wr = 1'b0;
  take = 1'b0;
  case (in[6:0])
    7'h37: begin res = {in[31:12], 12'b0}; wr = 1'b1; end
    7'h17: begin res = ref_pc + {in[31:12], 12'b0}; wr = 1'b1; end
    7'h6f: begin res = ref_pc + 32'd4; nxt = ref_pc + imm_j; wr = 1'b1; end
    7'h67: begin res = ref_pc + 32'd4; nxt = (a + imm_i) & ~32'd1; wr = 1'b1; end
    7'h63: begin
      case (f3)
        3'd0: take = (a == b);
        3'd1: take = (a != b);
        3'd4: take = ($signed(a) < $signed(b));
        3'd5: take = ($signed(a) >= $signed(b));
        3'd6: take = (a < b);
        3'd7: take = (a >= b);
        default: take = 1'b0;
      endcase
      if (take) nxt = ref_pc + imm_b;
    end
    7'h03: begin
      ea = a + imm_i;
      off = ea[1:0];
      word = ref_dmem[ea[9:2]] >> (8 * off);
      case (f3)
        3'd0: begin res = {{24{word[7]}}, word[7:0]}; wr = 1'b1; end
        3'd4: begin res = {24'b0, word[7:0]}; wr = 1'b1; end
        3'd1: begin res = {{16{word[15]}}, word[15:0]}; wr = !off[0]; end
        3'd5: begin res = {16'b0, word[15:0]}; wr = !off[0]; end
        3'd2: begin res = word; wr = (off == 2'd0); end
        default: wr = 1'b0;
      endcase
    end
    7'h23: begin
      ea = a + imm_s;
      off = ea[1:0];
      addr_o = {ea[31:2], 2'b00};
      case (f3)
        3'd0: begin be_o = 4'b0001 << off; wdata_o = {4{b[7:0]}}; end
        3'd1: begin
          if (!off[0]) be_o = off[1] ? 4'b1100 : 4'b0011;
          wdata_o = {2{b[15:0]}};
        end
        3'd2: begin if (off == 2'd0) be_o = 4'b1111; wdata_o = b; end
        default: be_o = '0;
      endcase
      for (int k = 0; k < 4; k++) begin
        if (be_o[k]) ref_dmem[ea[9:2]][8*k +: 8] = wdata_o[8*k +: 8];
      end
    end
    7'h13: begin
      res = alu_ref(f3, (f3 == 3'd5) && in[30], a, imm_i);
      wr = 1'b1;
    end
    7'h33: begin res = alu_ref(f3, in[30], a, b); wr = 1'b1; end
    7'h73: if (in[31:7] == '0) begin halt_o = 1'b1; nxt = ref_pc; end
    default: wr = 1'b0;
  endcase
  if (wr && in.r_fmt.rd != 5'd0) ref_regs[in.r_fmt.rd] = res;
  ref_pc = nxt;
endfunction

`endif

// File: sim/tb_rv_core.sv
// ==============================
// Testbench for the RV32I core
// Builds one program, models both memories, checks each cycle
// against the reference model until ECALL has held for 5 cycles
// ==============================
`include "rv_config.svh"

module tb_rv_core;

  `include "tb_iss.svh"

  logic             clk;
  logic             rst;
  logic [`XLEN-1:0] i_imem_data;
  logic [`XLEN-1:0] i_dmem_rdata;
  logic [`XLEN-1:0] o_imem_addr, o_dmem_addr, o_dmem_wdata;
  logic [3:0]       o_dmem_we;
  logic             o_halt;

  logic [`XLEN-1:0] imem [1024];
  logic [`XLEN-1:0] dmem [256];
  logic [31:0]      prog [$];
  int               errors = 0;
  int               checks = 0;
  int               halt_cycles = 0;
  bit               checking = 0;
  bit               built = 0;
  int               slot = 0;

  rv_core u_dut (
    .clk          (clk),
    .rst          (rst),
    .i_imem_data  (i_imem_data),
    .i_dmem_rdata (i_dmem_rdata),
    .o_imem_addr  (o_imem_addr),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_halt       (o_halt)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Memory models, reads see the word before this edge's write
  assign i_imem_data  = imem[o_imem_addr[11:2]];
  assign i_dmem_rdata = dmem[o_dmem_addr[9:2]];

  always @(posedge clk) begin
    if (!rst) begin
      for (int k = 0; k < 4; k++) begin
        if (o_dmem_we[k]) dmem[o_dmem_addr[9:2]][8*k +: 8] <= o_dmem_wdata[8*k +: 8];
      end
    end
  end

  task automatic emit(input logic [31:0] w);
    prog.push_back(w);
  endtask

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  // LUI plus ADDI, with the upper part rounded for the signed low part
  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] up;
    up = v + 32'h800;
    emit({up[31:12], rd, 7'h37});
    emit(enc_i(v[11:0], rd, 3'd0, rd, 7'h13));
  endtask

  // Result stores go to a rotating slot above the base in x1
  task automatic store_result(input logic [4:0] rs);
    emit(enc_s(12'(slot * 4), rs, 5'd1, 3'd2));
    slot = (slot + 1) % 32;
  endtask

  task automatic random_alu_op();
    logic [2:0]  f3;
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] imm;
    logic        alt;
    f3  = 3'($urandom % 8);
    rd  = 5'(10 + $urandom % 6);
    rs1 = 5'(2 + $urandom % 14);
    rs2 = 5'(2 + $urandom % 14);
    alt = 1'($urandom % 2);
    if ($urandom % 2) begin
      alt = alt && (f3 == 3'd0 || f3 == 3'd5);
      emit({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33});
    end else begin
      imm = 12'($urandom);
      if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
      if (f3 == 3'd5) imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
      emit(enc_i(imm, rs1, f3, rd, 7'h13));
    end
    store_result(rd);
  endtask

  task automatic build_program();
    int p;
    logic [31:0] pairs [6];
    emit(enc_i(12'd256, 5'd0, 3'd0, 5'd1, 7'h13));
    for (int r = 2; r < 16; r++) load_const(5'(r), $urandom);
    for (int n = 0; n < 40; n++) random_alu_op();
    // Upper immediates and jumps with their link values
    emit({20'($urandom), 5'd16, 7'h37});
    store_result(5'd16);
    emit({20'($urandom), 5'd17, 7'h17});
    store_result(5'd17);
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd18, 7'h6f});
    emit(enc_i(12'd1, 5'd19, 3'd0, 5'd19, 7'h13));
    store_result(5'd18);
    p = prog.size();
    emit(enc_i(12'((p + 3) * 4 + 1), 5'd0, 3'd0, 5'd20, 7'h13));
    emit(enc_i(12'd0, 5'd20, 3'd0, 5'd21, 7'h67));
    emit(enc_i(12'd1, 5'd19, 3'd0, 5'd19, 7'h13));
    store_result(5'd21);
    // Equal, signed-less and unsigned-less pairs, both orders
    pairs = '{32'd5, 32'd5, -32'sd3, 32'd4, 32'd3, -32'sd1};
    for (int q = 0; q < 3; q++) begin
      load_const(5'd2, pairs[2*q]);
      load_const(5'd3, pairs[2*q+1]);
      foreach (pairs[c]) begin
        for (int s = 0; s < 2; s++) begin
          emit(enc_b(13'd8, s ? 5'd2 : 5'd3, s ? 5'd3 : 5'd2,
                     (c < 2) ? 3'(c) : 3'(c + 2)));
          emit(enc_i(12'd1, 5'd19, 3'd0, 5'd19, 7'h13));
        end
      end
    end
    // Stores at every offset, misaligned ones write nothing
    load_const(5'd5, $urandom);
    for (int o = 0; o < 4; o++) emit(enc_s(12'(128 + o), 5'd5, 5'd1, 3'd0));
    for (int o = 0; o < 4; o++) emit(enc_s(12'(136 + o), 5'd5, 5'd1, 3'd1));
    for (int o = 1; o < 4; o++) emit(enc_s(12'(144 + o), 5'd5, 5'd1, 3'd2));
    // Loads of a stored word at every offset
    emit(enc_s(12'd192, 5'd5, 5'd1, 3'd2));
    for (int o = 0; o < 4; o++) begin
      foreach (pairs[f]) begin
        if (f != 2 && f != 3 && f < 6) begin
          emit(enc_i(12'(192 + o), 5'd1, 3'(f), 5'd6, 7'h03));
          store_result(5'd6);
        end
      end
    end
    emit(enc_i(12'd77, 5'd0, 3'd0, 5'd7, 7'h13));
    emit(enc_i(12'd193, 5'd1, 3'd2, 5'd7, 7'h03));
    store_result(5'd7);
    emit(32'h0ff0_000f);
    emit(32'h0000_0073);
  endtask

  // Expected values come from the reference model each cycle
  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    assert (exp_v === act_v) else begin
      errors++;
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp_v, act_v);
    end
  endtask

  always @(negedge clk) begin
    logic [31:0] e_pc, e_addr, e_wdata, mask;
    logic [3:0]  e_be;
    logic        e_halt;
    if (checking) begin
      iss_step(e_pc, e_addr, e_wdata, e_be, e_halt);
      check_value("o_imem_addr", e_pc, o_imem_addr);
      check_value("o_halt", 32'(e_halt), 32'(o_halt));
      check_value("o_dmem_we", 32'(e_be), 32'(o_dmem_we));
      if (e_be != 4'b0) begin
        mask = {{8{e_be[3]}}, {8{e_be[2]}}, {8{e_be[1]}}, {8{e_be[0]}}};
        check_value("o_dmem_addr", e_addr, o_dmem_addr);
        check_value("o_dmem_wdata", e_wdata & mask, o_dmem_wdata & mask);
      end
      if (e_halt) halt_cycles++;
    end
  end

  initial begin
    logic [31:0] seed_ret;
    rst = 1'b1;
    seed_ret = $urandom(32'h5aac96b2);
    for (int i = 0; i < 1024; i++) imem[i] = 32'h0000_0013;
    for (int i = 0; i < 256; i++) dmem[i] = (32'(i) * 32'h9e37_79b9) ^ {4{8'(i)}};
    build_program();
    foreach (prog[i]) imem[i] = prog[i];
    ref_imem = imem;
    ref_dmem = dmem;
    ref_pc = '0;
    foreach (ref_regs[r]) ref_regs[r] = '0;
    built = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    checking = 1'b1;
    wait (halt_cycles >= 6);
    checking = 1'b0;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    wait (built);
    #((prog.size() + 20) * 4);
    $display("Timeout: the core did not reach a held ECALL in time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: src/alu_execute.sv
// ============================
// Execute stage
// Integer ALU, branch compare and jump/branch target adder
// Loads and stores get their byte address from the ALU add
// ============================
`include "rv_config.svh"

module alu_execute (
  input  logic [`XLEN-1:0]  i_pc,
  input  logic [`XLEN-1:0]  i_rs1_data,
  input  logic [`XLEN-1:0]  i_rs2_data,
  input  logic [`XLEN-1:0]  i_imm,
  input  core_pkg::alu_op_e i_alu_op,
  input  logic              i_use_imm,
  input  logic              i_use_pc,
  input  core_pkg::branch_e i_branch,
  output logic [`XLEN-1:0]  o_result,
  output logic [`XLEN-1:0]  o_target,
  output logic              o_taken
);

  localparam int SHAMT_W = $clog2(`XLEN);

  logic [`XLEN-1:0]   op_a, op_b, target_base, target_sum;
  logic [SHAMT_W-1:0] shamt;
  logic               is_jalr, eq, lt, ltu;

  assign op_a  = i_use_pc ? i_pc : i_rs1_data;
  assign op_b  = i_use_imm ? i_imm : i_rs2_data;
  assign shamt = op_b[SHAMT_W-1:0];

  // Branches decode with rs1/rs2 operands, so SLT and branches share these
  assign eq  = (op_a == op_b);
  assign lt  = ($signed(op_a) < $signed(op_b));
  assign ltu = (op_a < op_b);

  always_comb begin
    case (i_alu_op)
      core_pkg::ALU_ADD:  o_result = op_a + op_b;
      core_pkg::ALU_SUB:  o_result = op_a - op_b;
      core_pkg::ALU_SLL:  o_result = op_a << shamt;
      core_pkg::ALU_SLT:  o_result = {{(`XLEN-1){1'b0}}, lt};
      core_pkg::ALU_SLTU: o_result = {{(`XLEN-1){1'b0}}, ltu};
      core_pkg::ALU_XOR:  o_result = op_a ^ op_b;
      core_pkg::ALU_SRL:  o_result = op_a >> shamt;
      core_pkg::ALU_SRA:  o_result = $signed(op_a) >>> shamt;
      core_pkg::ALU_OR:   o_result = op_a | op_b;
      core_pkg::ALU_AND:  o_result = op_a & op_b;
      default:            o_result = op_b;
    endcase
  end

  always_comb begin
    case (i_branch)
      core_pkg::BR_EQ:   o_taken = eq;
      core_pkg::BR_NE:   o_taken = !eq;
      core_pkg::BR_LT:   o_taken = lt;
      core_pkg::BR_GE:   o_taken = !lt;
      core_pkg::BR_LTU:  o_taken = ltu;
      core_pkg::BR_GEU:  o_taken = !ltu;
      core_pkg::BR_JAL:  o_taken = 1'b1;
      core_pkg::BR_JALR: o_taken = 1'b1;
      default:           o_taken = 1'b0;
    endcase
  end

  // JALR jumps relative to rs1 and drops bit 0
  assign is_jalr     = (i_branch == core_pkg::BR_JALR);
  assign target_base = is_jalr ? i_rs1_data : i_pc;
  assign target_sum  = target_base + i_imm;
  assign o_target    = {target_sum[`XLEN-1:1], target_sum[0] & !is_jalr};

endmodule

// File: src/core_pkg.sv
// ============================
// Control encodings passed between core stages
// Decode produces them and execute/writeback consume them
// ============================
package core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU,
    BR_JAL,
    BR_JALR
  } branch_e;

  // Matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
  } mem_size_e;

  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_PC_STEP,
    WB_LOAD
  } wb_src_e;

endpackage

// File: src/insn_decode.sv
// ============================
// Instruction decoder
// Turns one RV32I word into register indices, immediate and controls
// Unknown encodings come out as no-ops
// ============================
`include "rv_config.svh"

module insn_decode (
  input  rv_isa_pkg::insn_t      i_insn,
  output logic [`REG_ADDR_W-1:0] o_rs1,
  output logic [`REG_ADDR_W-1:0] o_rs2,
  output logic [`REG_ADDR_W-1:0] o_rd,
  output logic [`XLEN-1:0]       o_imm,
  output core_pkg::alu_op_e      o_alu_op,
  output logic                   o_use_imm,
  output logic                   o_use_pc,
  output core_pkg::branch_e      o_branch,
  output logic                   o_mem_read,
  output logic                   o_mem_write,
  output core_pkg::mem_size_e    o_mem_size,
  output logic                   o_mem_unsigned,
  output core_pkg::wb_src_e      o_wb_src,
  output logic                   o_halt
);

  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_base, f7_alt;
  logic       reg_imm_ok, reg_reg_ok, load_ok, store_ok;

  function automatic core_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                        input logic alt);
    core_pkg::alu_op_e op;
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     op = core_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     op = core_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    op = core_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     op = core_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:      op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      op = core_pkg::ALU_OR;
      default:                op = core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign funct3  = i_insn.r_fmt.funct3;
  assign funct7  = i_insn.r_fmt.funct7;
  assign f7_base = (funct7 == rv_isa_pkg::FUNCT7_BASE);
  assign f7_alt  = (funct7 == rv_isa_pkg::FUNCT7_ALT);

  // Immediate shifts carry funct7 too, so only SLLI/SRLI/SRAI forms pass
  assign reg_imm_ok = (funct3 == rv_isa_pkg::F3_SLL) ? f7_base :
                      (funct3 == rv_isa_pkg::F3_SR)  ? (f7_base || f7_alt) : 1'b1;
  assign reg_reg_ok = f7_base || (f7_alt && (funct3 == rv_isa_pkg::F3_ADD_SUB ||
                                             funct3 == rv_isa_pkg::F3_SR));
  // LB LH LW LBU LHU and SB SH SW
  assign load_ok  = (funct3[1:0] != 2'b11) && !(funct3[2] && funct3[1]);
  assign store_ok = !funct3[2] && (funct3[1:0] != 2'b11);

  // Sign-extended immediates per format
  assign imm_i = {{(`XLEN-12){i_insn.i_fmt.imm[11]}}, i_insn.i_fmt.imm};
  assign imm_s = {{(`XLEN-12){i_insn.s_fmt.imm_11_5[6]}}, i_insn.s_fmt.imm_11_5,
                  i_insn.s_fmt.imm_4_0};
  assign imm_b = {{(`XLEN-12){i_insn.b_fmt.imm_12}}, i_insn.b_fmt.imm_11,
                  i_insn.b_fmt.imm_10_5, i_insn.b_fmt.imm_4_1, 1'b0};
  assign imm_j = {{(`XLEN-20){i_insn.j_fmt.imm_20}}, i_insn.j_fmt.imm_19_12,
                  i_insn.j_fmt.imm_11, i_insn.j_fmt.imm_10_1, 1'b0};
  assign imm_u = {i_insn.u_fmt.imm_31_12, 12'b0};

  assign o_rs1 = i_insn.r_fmt.rs1;
  assign o_rs2 = i_insn.r_fmt.rs2;
  assign o_rd  = i_insn.r_fmt.rd;
  assign o_mem_unsigned = funct3[2];

  always_comb begin
    o_imm       = '0;
    o_alu_op    = core_pkg::ALU_ADD;
    o_use_imm   = 1'b0;
    o_use_pc    = 1'b0;
    o_branch    = core_pkg::BR_NONE;
    o_mem_read  = 1'b0;
    o_mem_write = 1'b0;
    o_wb_src    = core_pkg::WB_NONE;
    o_halt      = 1'b0;
    case (funct3[1:0])
      2'b00:   o_mem_size = core_pkg::MEM_BYTE;
      2'b01:   o_mem_size = core_pkg::MEM_HALF;
      default: o_mem_size = core_pkg::MEM_WORD;
    endcase

    case (i_insn.r_fmt.opcode)
      rv_isa_pkg::OP_LUI: begin
        o_imm     = imm_u;
        o_alu_op  = core_pkg::ALU_PASS_B;
        o_use_imm = 1'b1;
        o_wb_src  = core_pkg::WB_ALU;
      end
      rv_isa_pkg::OP_AUIPC: begin
        o_imm     = imm_u;
        o_use_imm = 1'b1;
        o_use_pc  = 1'b1;
        o_wb_src  = core_pkg::WB_ALU;
      end
      rv_isa_pkg::OP_JAL: begin
        o_imm    = imm_j;
        o_branch = core_pkg::BR_JAL;
        o_wb_src = core_pkg::WB_PC_STEP;
      end
      rv_isa_pkg::OP_JALR: begin
        o_imm    = imm_i;
        o_branch = core_pkg::BR_JALR;
        o_wb_src = core_pkg::WB_PC_STEP;
      end
      rv_isa_pkg::OP_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          rv_isa_pkg::F3_BEQ:  o_branch = core_pkg::BR_EQ;
          rv_isa_pkg::F3_BNE:  o_branch = core_pkg::BR_NE;
          rv_isa_pkg::F3_BLT:  o_branch = core_pkg::BR_LT;
          rv_isa_pkg::F3_BGE:  o_branch = core_pkg::BR_GE;
          rv_isa_pkg::F3_BLTU: o_branch = core_pkg::BR_LTU;
          rv_isa_pkg::F3_BGEU: o_branch = core_pkg::BR_GEU;
          default:             o_branch = core_pkg::BR_NONE;
        endcase
      end
      rv_isa_pkg::OP_LOAD: begin
        o_imm      = imm_i;
        o_use_imm  = 1'b1;
        o_mem_read = load_ok;
        o_wb_src   = load_ok ? core_pkg::WB_LOAD : core_pkg::WB_NONE;
      end
      rv_isa_pkg::OP_STORE: begin
        o_imm       = imm_s;
        o_use_imm   = 1'b1;
        o_mem_write = store_ok;
      end
      rv_isa_pkg::OP_REG_IMM: begin
        o_imm     = imm_i;
        o_use_imm = 1'b1;
        o_alu_op  = alu_from_funct3(funct3, (funct3 == rv_isa_pkg::F3_SR) && f7_alt);
        o_wb_src  = reg_imm_ok ? core_pkg::WB_ALU : core_pkg::WB_NONE;
      end
      rv_isa_pkg::OP_REG_REG: begin
        o_alu_op = alu_from_funct3(funct3, f7_alt);
        o_wb_src = reg_reg_ok ? core_pkg::WB_ALU : core_pkg::WB_NONE;
      end
      // ECALL only, all bits above the opcode are zero
      rv_isa_pkg::OP_ENVIRON: o_halt = (i_insn[31:7] == '0);
      // FENCE falls through as a no-op
      default: o_halt = 1'b0;
    endcase
  end

  // A store never also loads
  always_comb begin
    assert (!(o_mem_read && o_mem_write));
  end

endmodule

// File: src/pc_writeback.sv
// ============================
// PC register and result stage
// Picks the next PC, lays out store lanes, extracts load data
// and selects what goes back to the register file
// ============================
`include "rv_config.svh"

module pc_writeback (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_halt,
  input  logic                   i_taken,
  input  logic [`XLEN-1:0]       i_target,
  input  logic [`XLEN-1:0]       i_result,
  input  core_pkg::wb_src_e      i_wb_src,
  input  logic [`REG_ADDR_W-1:0] i_rd,
  input  logic                   i_mem_read,
  input  logic                   i_mem_write,
  input  core_pkg::mem_size_e    i_mem_size,
  input  logic                   i_mem_unsigned,
  input  logic [`XLEN-1:0]       i_rs2_data,
  input  logic [`XLEN-1:0]       i_dmem_rdata,
  output logic [`XLEN-1:0]       o_pc,
  output logic [`XLEN-1:0]       o_dmem_addr,
  output logic [`XLEN-1:0]       o_dmem_wdata,
  output logic [3:0]             o_dmem_we,
  output logic                   o_rd_we,
  output logic [`XLEN-1:0]       o_rd_data
);

  logic [`XLEN-1:0] pc, pc_step, next_pc, load_word, load_data;
  logic [3:0]       store_be;
  logic [1:0]       offset;
  logic             misaligned;

  assign pc_step = pc + `PC_STEP;
  assign o_pc    = pc;

  // ECALL never branches, so taken and halt do not overlap
  always_comb begin
    if (i_taken) begin
      next_pc = i_target;
    end else if (i_halt) begin
      next_pc = pc;
    end else begin
      next_pc = pc_step;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= next_pc;
    end
  end

  // Byte offset inside the addressed word
  assign offset      = i_result[1:0];
  assign o_dmem_addr = {i_result[`XLEN-1:2], 2'b00};
  assign misaligned  = ((i_mem_size == core_pkg::MEM_HALF) && offset[0]) ||
                       ((i_mem_size == core_pkg::MEM_WORD) && (offset != 2'b00));

  // Store data is repeated across lanes and the enables pick the lanes
  always_comb begin
    case (i_mem_size)
      core_pkg::MEM_BYTE: begin
        store_be     = 4'b0001 << offset;
        o_dmem_wdata = {4{i_rs2_data[7:0]}};
      end
      core_pkg::MEM_HALF: begin
        store_be     = 4'b0011 << offset;
        o_dmem_wdata = {2{i_rs2_data[15:0]}};
      end
      default: begin
        store_be     = 4'b1111;
        o_dmem_wdata = i_rs2_data;
      end
    endcase
  end

  assign o_dmem_we = (i_mem_write && !misaligned) ? store_be : 4'b0000;

  assign load_word = i_dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (i_mem_size)
      core_pkg::MEM_BYTE:
        load_data = {{(`XLEN-8){load_word[7] & !i_mem_unsigned}}, load_word[7:0]};
      core_pkg::MEM_HALF:
        load_data = {{(`XLEN-16){load_word[15] & !i_mem_unsigned}}, load_word[15:0]};
      default: load_data = load_word;
    endcase
  end

  // Misaligned half and word loads leave rd untouched
  assign o_rd_we = (i_wb_src != core_pkg::WB_NONE) && (i_rd != '0) &&
                   !(i_mem_read && misaligned);

  always_comb begin
    case (i_wb_src)
      core_pkg::WB_PC_STEP: o_rd_data = pc_step;
      core_pkg::WB_LOAD:    o_rd_data = load_data;
      default:              o_rd_data = i_result;
    endcase
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

  a_we_legal: assert property (@(posedge clk) disable iff (rst)
    o_dmem_we inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111});

endmodule

// File: src/reg_file.sv
// ============================
// Integer register file
// Two combinational reads and one write per clk, x0 reads as zero
// ============================
`include "rv_config.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`REG_ADDR_W-1:0] i_rs1,
  input  logic [`REG_ADDR_W-1:0] i_rs2,
  input  logic [`REG_ADDR_W-1:0] i_rd,
  input  logic                   i_we,
  input  logic [`XLEN-1:0]       i_rd_data,
  output logic [`XLEN-1:0]       o_rs1_data,
  output logic [`XLEN-1:0]       o_rs2_data
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  // x0 is cleared on reset and never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  a_x0_rs1_zero: assert property (@(posedge clk) disable iff (rst)
    (i_rs1 == '0) |-> (o_rs1_data == '0));

  a_x0_rs2_zero: assert property (@(posedge clk) disable iff (rst)
    (i_rs2 == '0) |-> (o_rs2_data == '0));

endmodule

// File: src/rv_config.svh
// ============================
// Core-wide sizing macros for the RV32I core
// Include in any file that sizes a port or register by them
// ============================
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Register and address width
`define XLEN 32

// Register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// Byte increment of a sequential PC
`define PC_STEP 4

`endif

// File: src/rv_core.sv
// ============================
// RV32I single-cycle core
// One instruction retires per clk until ECALL raises halt
// Instruction and data memories sit outside on plain ports
// ============================
`include "rv_config.svh"

module rv_core (
  input  logic             clk,
  input  logic             rst,
  input  logic [`XLEN-1:0] i_imem_data,
  input  logic [`XLEN-1:0] i_dmem_rdata,
  output logic [`XLEN-1:0] o_imem_addr,
  output logic [`XLEN-1:0] o_dmem_addr,
  output logic [`XLEN-1:0] o_dmem_wdata,
  output logic [3:0]       o_dmem_we,
  output logic             o_halt
);

  logic [`REG_ADDR_W-1:0] rs1, rs2, rd;
  logic [`XLEN-1:0]       imm, rs1_data, rs2_data, result, target, rd_data;
  logic                   use_imm, use_pc, mem_read, mem_write, mem_unsigned;
  logic                   taken, rd_we;
  core_pkg::alu_op_e      alu_op;
  core_pkg::branch_e      branch;
  core_pkg::mem_size_e    mem_size;
  core_pkg::wb_src_e      wb_src;

  insn_decode u_decode (
    .i_insn         (i_imem_data),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (rd),
    .o_imm          (imm),
    .o_alu_op       (alu_op),
    .o_use_imm      (use_imm),
    .o_use_pc       (use_pc),
    .o_branch       (branch),
    .o_mem_read     (mem_read),
    .o_mem_write    (mem_write),
    .o_mem_size     (mem_size),
    .o_mem_unsigned (mem_unsigned),
    .o_wb_src       (wb_src),
    .o_halt         (o_halt)
  );

  reg_file u_regs (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rd       (rd),
    .i_we       (rd_we),
    .i_rd_data  (rd_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  alu_execute u_execute (
    .i_pc       (o_imem_addr),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_imm      (imm),
    .i_alu_op   (alu_op),
    .i_use_imm  (use_imm),
    .i_use_pc   (use_pc),
    .i_branch   (branch),
    .o_result   (result),
    .o_target   (target),
    .o_taken    (taken)
  );

  pc_writeback u_result (
    .clk            (clk),
    .rst            (rst),
    .i_halt         (o_halt),
    .i_taken        (taken),
    .i_target       (target),
    .i_result       (result),
    .i_wb_src       (wb_src),
    .i_rd           (rd),
    .i_mem_read     (mem_read),
    .i_mem_write    (mem_write),
    .i_mem_size     (mem_size),
    .i_mem_unsigned (mem_unsigned),
    .i_rs2_data     (rs2_data),
    .i_dmem_rdata   (i_dmem_rdata),
    .o_pc           (o_imem_addr),
    .o_dmem_addr    (o_dmem_addr),
    .o_dmem_wdata   (o_dmem_wdata),
    .o_dmem_we      (o_dmem_we),
    .o_rd_we        (rd_we),
    .o_rd_data      (rd_data)
  );

endmodule

// File: src/rv_isa_pkg.sv
// ============================
// RV32I instruction encodings
// Opcodes, funct fields and the per-format views of one word
// ============================
package rv_isa_pkg;

  typedef enum logic [6:0] {
    OP_LOAD     = 7'b00_000_11,
    OP_STORE    = 7'b01_000_11,
    OP_BRANCH   = 7'b11_000_11,
    OP_JALR     = 7'b11_001_11,
    OP_MISC_MEM = 7'b00_011_11,
    OP_JAL      = 7'b11_011_11,
    OP_REG_IMM  = 7'b00_100_11,
    OP_REG_REG  = 7'b01_100_11,
    OP_ENVIRON  = 7'b11_100_11,
    OP_AUIPC    = 7'b00_101_11,
    OP_LUI      = 7'b01_101_11
  } opcode_e;

  // Alternate encoding selects SUB and SRA/SRAI
  localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b010_0000;

  // Integer ALU funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  // One instruction word, read through whichever format its opcode implies
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } insn_t;

endpackage
